// ==== bench/tb_xif_checks.svh ====
`ifndef TB_XIF_CHECKS_SVH
`define TB_XIF_CHECKS_SVH

////////////////////
// compare tasks
////////////////////

// offload ids
task automatic check_id(input string name, input xif_id_t act, input xif_id_t exp);
  if (act !== exp) begin
    $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
    fail_run();
  end
endtask

// issue mode
task automatic check_mode(input string name, input xif_mode_t act, input xif_mode_t exp);
  if (act !== exp) begin
    $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
    fail_run();
  end
endtask

// per operand bits, valid and forwarding
task automatic check_vec(input string name, input logic [NUM_RS-1:0] act,
                         input logic [NUM_RS-1:0] exp);
  if (act !== exp) begin
    $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
    fail_run();
  end
endtask

// single strobes
task automatic check_bit(input string name, input logic act, input logic exp);
  if (act !== exp) begin
    $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
    fail_run();
  end
endtask

// 32 bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

`endif

// ==== bench/tb_xif_offload.sv ====
`timescale 1ns/1ps

module tb_xif_offload;
  import xif_pkg::*;

  localparam int unsigned NUM_RS      = 3;
  localparam time         CLK_PERIOD  = 20ns;
  localparam time         DRIVE_DLY   = 2ns;
  localparam time         SAMPLE_DLY  = 16ns;
  localparam int          TIMEOUT_CYC = 20;

  // dut ports, same names so .* can bind them
  logic                   clk_i;
  logic                   rst_ni;
  logic                   issue_valid_o, issue_ready_i;
  logic                   issue_resp_accept_i, issue_resp_writeback_i, issue_resp_loadstore_i;
  xif_id_t                issue_id_o, compressed_id_o, commit_id_o;
  xif_mode_t              issue_mode_o;
  logic                   commit_valid_o;
  logic [NUM_RS-1:0]      rs_valid_o, ex_fwd_o, wb_fwd_o, regs_used_i;
  logic                   mem_valid_i, mem_ready_o, mem_data_req_o, mem_result_valid_o;
  logic                   mem_instr_wb_i, wb_ready_i;
  logic                   result_valid_i, result_we_i;
  reg_addr_t              result_rd_i, rd_i, waddr_ex_i, waddr_wb_i, mem_waddr_ex_i;
  reg_addr_t [NUM_RS-1:0] rs_addr_i;
  logic                   instr_valid_i, illegal_dec_i, branch_or_jump_i, id_ready_i;
  logic                   data_req_dec_i;
  priv_lvl_e              priv_lvl_i;
  logic                   ex_valid_i, ex_ready_i, we_ex_i, we_wb_i, mem_we_ex_i;
  logic                   stall_o, illegal_o;

  // one table row, stimulus first then expected values
  typedef struct packed {
    logic                   iv, ill, idr, bj;
    priv_lvl_e              priv;
    reg_addr_t              rd;
    reg_addr_t [NUM_RS-1:0] rs;
    logic [NUM_RS-1:0]      used;
    logic [3:0]             lat;
    logic                   acc, wbk, ls;
    logic                   res_v, res_we;
    reg_addr_t              res_rd;
    logic                   dreq, mem_v, ex_rdy, ex_v, mwb, wb_rdy;
    logic                   we_ex, we_wb, mem_we;
    reg_addr_t              wa_ex, wa_wb, mem_wa;
    logic                   e_valid, e_stall, e_ill, e_mreq, e_mres;
    logic [NUM_RS-1:0]      e_rsv, e_exf, e_wbf;
    xif_id_t                e_id, e_cid;
    xif_mode_t              e_mode;
  } row_t;

  row_t        rows[$];
  row_t        cur;
  xif_id_t     nid;
  xif_mode_t   mode_exp [0:3];
  logic [31:0] seed;

  xif_offload_top #(.NUM_RS(NUM_RS), .MEM_CNT_W(4)) u_xif_offload_top (.*);

  task automatic fail_run();
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_xif_checks.svh"

  ////////////////////
  // table building
  ////////////////////

  // idle core, nothing in flight, wb address parked at r31
  task automatic new_row();
    cur        = '0;
    cur.idr    = 1'b1;
    cur.priv   = PRIV_LVL_M;
    cur.acc    = 1'b1;
    cur.ex_rdy = 1'b1;
    cur.wa_wb  = reg_addr_t'(31);
    cur.e_rsv  = '1;
  endtask

  // instruction the core decoder rejects, expected to go out
  task automatic offload_row();
    new_row();
    cur.iv      = 1'b1;
    cur.ill     = 1'b1;
    cur.e_valid = 1'b1;
  endtask

  // ids follow the count of accepted offloads
  task automatic push_row();
    cur.e_id   = nid;
    cur.e_cid  = cur.e_valid ? nid + xif_id_t'(1) : nid;
    cur.e_mode = mode_exp[cur.priv];
    if (cur.e_valid) begin
      nid = nid + xif_id_t'(1);
    end
    rows.push_back(cur);
  endtask

  task automatic build_table();
    int i;
    int k;
    nid = '0;
    seed = 32'd78;
    mode_exp[PRIV_LVL_M] = 2'd3;
    mode_exp[PRIV_LVL_H] = 2'd2;
    mode_exp[PRIV_LVL_S] = 2'd1;
    mode_exp[PRIV_LVL_U] = 2'd0;

    // reset state
    new_row();
    push_row();

    // back to back offloads, id wraps past 15, all four modes
    for (i = 0; i < 18; i++) begin
      offload_row();
      cur.priv = priv_lvl_e'(i[1:0]);
      push_row();
    end

    // r5 pending after a writeback offload
    offload_row();
    cur.rd  = reg_addr_t'(5);
    cur.wbk = 1'b1;
    push_row();
    new_row();
    cur.iv      = 1'b1;
    cur.rs[0]   = reg_addr_t'(5);
    cur.used    = 3'b001;
    cur.e_stall = 1'b1;
    cur.e_rsv   = 3'b110;
    push_row();
    // result for r5 arrives, hazard gone, entry clears next cycle
    cur.res_v   = 1'b1;
    cur.res_we  = 1'b1;
    cur.res_rd  = reg_addr_t'(5);
    cur.e_stall = 1'b0;
    push_row();
    cur.res_v = 1'b0;
    cur.e_rsv = '1;
    push_row();

    // load in ex targets rs1, rs2 hits wb while ex is idle
    new_row();
    cur.rs[1]  = reg_addr_t'(12);
    cur.rs[2]  = reg_addr_t'(31);
    cur.mem_we = 1'b1;
    cur.mem_wa = reg_addr_t'(12);
    cur.e_rsv  = 3'b001;
    push_row();

    // random sources against ex and wb write ports
    for (i = 0; i < 8; i++) begin
      new_row();
      seed      = xorshift32(seed);
      cur.iv    = 1'b1;
      cur.ex_v  = seed[12];
      cur.we_ex = seed[0];
      cur.we_wb = seed[1];
      cur.wa_ex = seed[6:2];
      cur.wa_wb = seed[11:7];
      for (k = 0; k < NUM_RS; k++) begin
        seed = xorshift32(seed);
        // bias towards hits on either port
        if (seed[1:0] == 2'd0) begin
          cur.rs[k] = cur.wa_ex;
        end else if (seed[1:0] == 2'd1) begin
          cur.rs[k] = cur.wa_wb;
        end else begin
          cur.rs[k] = seed[6:2];
        end
        cur.e_exf[k] = (cur.rs[k] == cur.wa_ex) && cur.we_ex && cur.ex_v;
        cur.e_wbf[k] = (cur.rs[k] == cur.wa_wb) && cur.we_wb && cur.ex_v;
        // wb target is not yet readable while ex is empty
        cur.e_rsv[k] = !((cur.rs[k] == cur.wa_wb) && !cur.ex_v);
      end
      push_row();
    end

    // ex forward of rs0 while a result is returning
    offload_row();
    cur.ex_v    = 1'b1;
    cur.we_ex   = 1'b1;
    cur.wa_ex   = reg_addr_t'(7);
    cur.rs[0]   = reg_addr_t'(7);
    cur.e_exf   = 3'b001;
    cur.res_v   = 1'b1;
    cur.res_rd  = reg_addr_t'(9);
    cur.e_valid = 1'b0;
    cur.e_stall = 1'b1;
    push_row();
    cur.res_v   = 1'b0;
    cur.e_valid = 1'b1;
    cur.e_stall = 1'b0;
    push_row();

    // branches and jumps stay in the core
    offload_row();
    cur.bj      = 1'b1;
    cur.e_valid = 1'b0;
    push_row();

    // coprocessor refuses
    offload_row();
    cur.acc   = 1'b0;
    cur.e_ill = 1'b1;
    push_row();
    // ready comes late
    offload_row();
    cur.lat = 4'd3;
    push_row();
    // id stage holds, offload only once
    offload_row();
    cur.idr = 1'b0;
    push_row();
    cur.e_valid = 1'b0;
    push_row();
    cur.idr = 1'b1;
    push_row();
    offload_row();
    push_row();

    // load/store offload then core data access
    offload_row();
    cur.ls = 1'b1;
    push_row();
    new_row();
    cur.dreq    = 1'b1;
    cur.e_stall = 1'b1;
    push_row();
    // request waits while ex not ready
    cur.mem_v  = 1'b1;
    cur.ex_rdy = 1'b0;
    push_row();
    cur.ex_rdy = 1'b1;
    cur.e_mreq = 1'b1;
    push_row();
    new_row();
    cur.dreq   = 1'b1;
    cur.mwb    = 1'b1;
    cur.wb_rdy = 1'b1;
    cur.e_mres = 1'b1;
    push_row();
    cur.wb_rdy = 1'b0;
    cur.e_mres = 1'b0;
    push_row();
  endtask

  ////////////////////
  // drive and check
  ////////////////////

  task automatic drive_row(input row_t r);
    instr_valid_i          = r.iv;
    illegal_dec_i          = r.ill;
    id_ready_i             = r.idr;
    branch_or_jump_i       = r.bj;
    priv_lvl_i             = r.priv;
    rd_i                   = r.rd;
    rs_addr_i              = r.rs;
    regs_used_i            = r.used;
    issue_ready_i          = (r.lat == 4'd0);
    issue_resp_accept_i    = r.acc;
    issue_resp_writeback_i = r.wbk;
    issue_resp_loadstore_i = r.ls;
    result_valid_i         = r.res_v;
    result_we_i            = r.res_we;
    result_rd_i            = r.res_rd;
    data_req_dec_i         = r.dreq;
    mem_valid_i            = r.mem_v;
    ex_ready_i             = r.ex_rdy;
    ex_valid_i             = r.ex_v;
    mem_instr_wb_i         = r.mwb;
    wb_ready_i             = r.wb_rdy;
    we_ex_i                = r.we_ex;
    we_wb_i                = r.we_wb;
    waddr_ex_i             = r.wa_ex;
    waddr_wb_i             = r.wa_wb;
    mem_we_ex_i            = r.mem_we;
    mem_waddr_ex_i         = r.mem_wa;
  endtask

  task automatic check_row(input row_t r);
    check_bit("issue_valid_o", issue_valid_o, r.e_valid);
    check_bit("commit_valid_o", commit_valid_o, r.e_valid);
    check_bit("stall_o", stall_o, r.e_stall);
    check_bit("illegal_o", illegal_o, r.e_ill);
    check_bit("mem_ready_o", mem_ready_o, r.ex_rdy);
    check_bit("mem_data_req_o", mem_data_req_o, r.e_mreq);
    check_bit("mem_result_valid_o", mem_result_valid_o, r.e_mres);
    check_vec("rs_valid_o", rs_valid_o, r.e_rsv);
    check_vec("ex_fwd_o", ex_fwd_o, r.e_exf);
    check_vec("wb_fwd_o", wb_fwd_o, r.e_wbf);
    check_id("issue_id_o", issue_id_o, r.e_id);
    check_id("commit_id_o", commit_id_o, r.e_id);
    check_id("compressed_id_o", compressed_id_o, r.e_cid);
    check_mode("issue_mode_o", issue_mode_o, r.e_mode);
  endtask

  // coprocessor model raises ready after r.lat cycles
  task automatic wait_issue_ready(input row_t r);
    int waited;
    waited = 0;
    while (!(issue_valid_o && issue_ready_i)) begin
      check_bit("issue_valid_o", issue_valid_o, 1'b1);
      check_bit("stall_o", stall_o, 1'b1);
      check_id("compressed_id_o", compressed_id_o, r.e_id);
      waited++;
      if (waited > TIMEOUT_CYC) begin
        $display("issue ready never came within %0d cycles", TIMEOUT_CYC);
        fail_run();
      end
      @(posedge clk_i);
      #DRIVE_DLY;
      issue_ready_i = (waited >= r.lat);
      #SAMPLE_DLY;
    end
  endtask

  ////////////////////
  // clock and run
  ////////////////////

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    rst_ni = 1'b0;
    build_table();
    new_row();
    drive_row(cur);
    repeat (4) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    foreach (rows[k]) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      drive_row(rows[k]);
      #SAMPLE_DLY;
      if (rows[k].lat != 4'd0) begin
        wait_issue_ready(rows[k]);
      end
      check_row(rows[k]);
    end
    @(posedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+bench
source/xif_pkg.sv
source/xif_issue_if.sv
source/xif_scoreboard.sv
source/xif_mem_tracker.sv
source/xif_dispatcher.sv
source/xif_offload_top.sv
bench/tb_xif_offload.sv

// ==== source/xif_dispatcher.sv ====
`timescale 1ns/1ps

module xif_dispatcher #(
  parameter int unsigned NUM_RS = 3
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  xif_issue_if.disp           issue_if,

  // from scoreboard and memory tracker
  input  logic [NUM_RS-1:0]   rs_pending_i,
  input  logic                rs_dep_i,
  input  logic                mem_outstanding_i,

  // core decode status
  input  logic                instr_valid_i,
  input  logic                illegal_dec_i,
  input  logic                branch_or_jump_i,
  input  logic                id_ready_i,
  input  logic                ex_valid_i,
  input  logic                ex_ready_i,
  input  xif_pkg::priv_lvl_e  priv_lvl_i,

  // pipeline write ports for forwarding
  input  xif_pkg::reg_addr_t  waddr_ex_i,
  input  xif_pkg::reg_addr_t  waddr_wb_i,
  input  logic                we_ex_i,
  input  logic                we_wb_i,
  input  xif_pkg::reg_addr_t  mem_waddr_ex_i,
  input  logic                mem_we_ex_i,

  // result and memory strobes
  input  logic                result_valid_i,
  input  logic                mem_valid_i,
  input  logic                mem_instr_wb_i,
  input  logic                wb_ready_i,

  // issue request fields
  output xif_pkg::xif_id_t    issue_id_o,
  output xif_pkg::xif_mode_t  issue_mode_o,
  output logic [NUM_RS-1:0]   rs_valid_o,
  output logic [NUM_RS-1:0]   ex_fwd_o,
  output logic [NUM_RS-1:0]   wb_fwd_o,
  output xif_pkg::xif_id_t    compressed_id_o,

  // commit
  output logic                commit_valid_o,
  output xif_pkg::xif_id_t    commit_id_o,

  // memory channel
  output logic                mem_ready_o,
  output logic                mem_data_req_o,
  output logic                mem_result_valid_o,

  // core status
  output logic                stall_o,
  output logic                illegal_o
);
  import xif_pkg::*;

  xif_id_t id_q;
  xif_id_t id_d;
  logic    offloaded_q;
  logic    offloaded_d;
  logic    fire;
  logic    fwd_collision;
  logic    not_ready;
  logic    mem_no_fire;

  ////////////////////
  // issue gating
  ////////////////////

  // EX forward would race with a result write
  assign fwd_collision = result_valid_i & (|ex_fwd_o);

  assign issue_if.issue_valid = instr_valid_i & illegal_dec_i & ~branch_or_jump_i
                              & ~offloaded_q & ~fwd_collision;

  assign fire = issue_if.issue_valid & issue_if.issue_ready;

  // coprocessor refused it too
  assign illegal_o = fire & ~issue_if.resp_accept;

  ////////////////////
  // operands
  ////////////////////

  // forward only while EX holds a live instruction
  always_comb begin
    for (int i = 0; i < NUM_RS; i++) begin
      ex_fwd_o[i] = (issue_if.rs_addr[i] == waddr_ex_i) & we_ex_i & ex_valid_i;
      wb_fwd_o[i] = (issue_if.rs_addr[i] == waddr_wb_i) & we_wb_i & ex_valid_i;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_RS; i++) begin
      rs_valid_o[i] = (~rs_pending_i[i] | ex_fwd_o[i] | wb_fwd_o[i])
                    & ~((issue_if.rs_addr[i] == mem_waddr_ex_i) & mem_we_ex_i)
                    & ~((issue_if.rs_addr[i] == waddr_wb_i) & ~ex_valid_i);
    end
  end

  ////////////////////
  // id and mode
  ////////////////////

  assign id_d = fire ? id_q + xif_id_t'(1) : id_q;

  assign issue_id_o      = id_q;
  assign commit_id_o     = id_q;
  assign compressed_id_o = id_d;
  assign commit_valid_o  = issue_if.issue_valid;

  always_comb begin
    unique case (priv_lvl_i)
      PRIV_LVL_M: issue_mode_o = XIF_MODE_M;
      PRIV_LVL_H: issue_mode_o = XIF_MODE_H;
      PRIV_LVL_S: issue_mode_o = XIF_MODE_S;
      PRIV_LVL_U: issue_mode_o = XIF_MODE_U;
      default:    issue_mode_o = XIF_MODE_M;
    endcase
  end

  // set on fire, dropped once ID moves on
  always_comb begin
    offloaded_d = offloaded_q;
    if (id_ready_i) begin
      offloaded_d = 1'b0;
    end else if (fire) begin
      offloaded_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q        <= '0;
      offloaded_q <= 1'b0;
    end else begin
      id_q        <= id_d;
      offloaded_q <= offloaded_d;
    end
  end

  ////////////////////
  // memory and stall
  ////////////////////

  assign mem_ready_o        = ex_ready_i;
  assign mem_data_req_o     = mem_valid_i & mem_ready_o;
  assign mem_result_valid_o = mem_instr_wb_i & wb_ready_i;

  assign not_ready   = issue_if.issue_valid & ~issue_if.issue_ready;
  assign mem_no_fire = mem_data_req_o & ~fire;

  assign stall_o = rs_dep_i | mem_outstanding_i | not_ready | mem_no_fire | fwd_collision;

endmodule

// ==== source/xif_issue_if.sv ====
`timescale 1ns/1ps

interface xif_issue_if #(
  parameter int unsigned NUM_RS = 3
);
  import xif_pkg::*;

  // handshake
  logic issue_valid;
  logic issue_ready;

  // coprocessor response, only meaningful on fire
  logic resp_accept;
  logic resp_writeback;
  logic resp_loadstore;

  // instruction currently in ID
  reg_addr_t              rd;
  reg_addr_t [NUM_RS-1:0] rs_addr;

  // dispatcher raises valid and reacts to the response
  modport disp (
    output issue_valid,
    input  issue_ready, resp_accept, resp_writeback, resp_loadstore, rd, rs_addr
  );

  // scoreboard observes the whole issue
  modport sb (
    input issue_valid, issue_ready, resp_accept, resp_writeback, resp_loadstore,
    input rd, rs_addr
  );

  // memory tracker only needs load/store fires
  modport mem (
    input issue_valid, issue_ready, resp_loadstore
  );

endinterface

// ==== source/xif_mem_tracker.sv ====
`timescale 1ns/1ps

module xif_mem_tracker #(
  parameter int unsigned MEM_CNT_W = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  xif_issue_if.mem issue_if,

  // memory request accepted by the core this cycle
  input  logic     mem_data_req_i,
  // core decoder wants its own data access
  input  logic     data_req_dec_i,
  output logic     mem_outstanding_o
);

  localparam logic [MEM_CNT_W-1:0] CNT_ONE = MEM_CNT_W'(1);

  logic [MEM_CNT_W-1:0] cnt_q;
  logic [MEM_CNT_W-1:0] cnt_d;
  logic                 inc;
  logic                 dec;

  // offloaded load/store still waiting for its request
  assign inc = issue_if.issue_valid & issue_if.issue_ready & issue_if.resp_loadstore;
  assign dec = mem_data_req_i;

  // hold when both or neither
  always_comb begin
    cnt_d = cnt_q;
    if (inc && !dec) begin
      cnt_d = cnt_q + CNT_ONE;
    end else if (dec && !inc) begin
      cnt_d = cnt_q - CNT_ONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // keep core accesses behind pending coprocessor ones
  assign mem_outstanding_o = data_req_dec_i & (cnt_q != '0);

endmodule

// ==== source/xif_offload_top.sv ====
`timescale 1ns/1ps

module xif_offload_top #(
  parameter int unsigned NUM_RS    = 3,
  parameter int unsigned MEM_CNT_W = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // issue channel
  output logic                            issue_valid_o,
  input  logic                            issue_ready_i,
  input  logic                            issue_resp_accept_i,
  input  logic                            issue_resp_writeback_i,
  input  logic                            issue_resp_loadstore_i,
  output xif_pkg::xif_id_t                issue_id_o,
  output xif_pkg::xif_mode_t              issue_mode_o,
  output logic [NUM_RS-1:0]               rs_valid_o,
  output xif_pkg::xif_id_t                compressed_id_o,

  // commit
  output logic                            commit_valid_o,
  output xif_pkg::xif_id_t                commit_id_o,

  // memory and memory result
  input  logic                            mem_valid_i,
  output logic                            mem_ready_o,
  output logic                            mem_data_req_o,
  output logic                            mem_result_valid_o,
  input  logic                            mem_instr_wb_i,
  input  logic                            wb_ready_i,

  // result channel
  input  logic                            result_valid_i,
  input  xif_pkg::reg_addr_t              result_rd_i,
  input  logic                            result_we_i,

  // instruction in ID
  input  logic                            instr_valid_i,
  input  logic                            illegal_dec_i,
  input  logic                            branch_or_jump_i,
  input  logic                            id_ready_i,
  input  xif_pkg::priv_lvl_e              priv_lvl_i,
  input  xif_pkg::reg_addr_t              rd_i,
  input  xif_pkg::reg_addr_t [NUM_RS-1:0] rs_addr_i,
  input  logic [NUM_RS-1:0]               regs_used_i,
  input  logic                            data_req_dec_i,

  // pipeline state
  input  logic                            ex_valid_i,
  input  logic                            ex_ready_i,
  input  xif_pkg::reg_addr_t              waddr_ex_i,
  input  xif_pkg::reg_addr_t              waddr_wb_i,
  input  logic                            we_ex_i,
  input  logic                            we_wb_i,
  input  xif_pkg::reg_addr_t              mem_waddr_ex_i,
  input  logic                            mem_we_ex_i,
  output logic [NUM_RS-1:0]               ex_fwd_o,
  output logic [NUM_RS-1:0]               wb_fwd_o,

  // core status
  output logic                            stall_o,
  output logic                            illegal_o
);

  logic [NUM_RS-1:0] rs_pending;
  logic              rs_dep;
  logic              mem_outstanding;

  xif_issue_if #(.NUM_RS(NUM_RS)) u_issue_if ();

  // coprocessor side of the handshake
  assign u_issue_if.issue_ready    = issue_ready_i;
  assign u_issue_if.resp_accept    = issue_resp_accept_i;
  assign u_issue_if.resp_writeback = issue_resp_writeback_i;
  assign u_issue_if.resp_loadstore = issue_resp_loadstore_i;
  assign u_issue_if.rd             = rd_i;
  assign u_issue_if.rs_addr        = rs_addr_i;
  assign issue_valid_o             = u_issue_if.issue_valid;

  xif_dispatcher #(.NUM_RS(NUM_RS)) u_dispatcher (
    .clk_i, .rst_ni,
    .issue_if          (u_issue_if.disp),
    .rs_pending_i      (rs_pending),
    .rs_dep_i          (rs_dep),
    .mem_outstanding_i (mem_outstanding),
    .instr_valid_i, .illegal_dec_i, .branch_or_jump_i, .id_ready_i,
    .ex_valid_i, .ex_ready_i, .priv_lvl_i,
    .waddr_ex_i, .waddr_wb_i, .we_ex_i, .we_wb_i, .mem_waddr_ex_i, .mem_we_ex_i,
    .result_valid_i, .mem_valid_i, .mem_instr_wb_i, .wb_ready_i,
    .issue_id_o, .issue_mode_o, .rs_valid_o, .ex_fwd_o, .wb_fwd_o, .compressed_id_o,
    .commit_valid_o, .commit_id_o,
    .mem_ready_o, .mem_data_req_o, .mem_result_valid_o,
    .stall_o, .illegal_o
  );

  xif_scoreboard #(.NUM_RS(NUM_RS)) u_scoreboard (
    .clk_i, .rst_ni,
    .issue_if     (u_issue_if.sb),
    .result_valid_i, .result_rd_i, .result_we_i,
    .regs_used_i,
    .rs_pending_o (rs_pending),
    .rs_dep_o     (rs_dep)
  );

  // request strobe loops back from the dispatcher
  xif_mem_tracker #(.MEM_CNT_W(MEM_CNT_W)) u_mem_tracker (
    .clk_i, .rst_ni,
    .issue_if          (u_issue_if.mem),
    .mem_data_req_i    (mem_data_req_o),
    .data_req_dec_i,
    .mem_outstanding_o (mem_outstanding)
  );

endmodule

// ==== source/xif_pkg.sv ====
package xif_pkg;

  ////////////////////
  // register file
  ////////////////////

  // one scoreboard entry per integer register
  localparam int unsigned NUM_REGS = 32;

  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

  // offload id wraps modulo 16
  typedef logic [3:0] xif_id_t;

  ////////////////////
  // privilege and mode
  ////////////////////

  // privilege level of the instruction in ID
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_H = 2'b10,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // issue mode as seen by the coprocessor
  typedef logic [1:0] xif_mode_t;

  localparam xif_mode_t XIF_MODE_M = 2'd3;
  localparam xif_mode_t XIF_MODE_H = 2'd2;
  localparam xif_mode_t XIF_MODE_S = 2'd1;
  localparam xif_mode_t XIF_MODE_U = 2'd0;

endpackage

// ==== source/xif_scoreboard.sv ====
`timescale 1ns/1ps

module xif_scoreboard #(
  parameter int unsigned NUM_RS = 3
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  xif_issue_if.sb            issue_if,

  // result channel from the coprocessor
  input  logic               result_valid_i,
  input  xif_pkg::reg_addr_t result_rd_i,
  input  logic               result_we_i,

  // operand usage of the instruction in ID
  input  logic [NUM_RS-1:0]  regs_used_i,
  output logic [NUM_RS-1:0]  rs_pending_o,
  output logic               rs_dep_o
);
  import xif_pkg::*;

  logic [NUM_REGS-1:0] pending_q;
  logic [NUM_REGS-1:0] pending_d;
  logic                fire;
  logic                set_rd;
  logic                clr_result;

  ////////////////////
  // table update
  ////////////////////

  assign fire = issue_if.issue_valid & issue_if.issue_ready;

  // no set when the same register is being returned right now
  assign set_rd = fire & issue_if.resp_writeback
                & ~(result_valid_i & (result_rd_i == issue_if.rd));

  assign clr_result = result_valid_i & result_we_i;

  always_comb begin
    pending_d = pending_q;
    if (set_rd) begin
      pending_d[issue_if.rd] = 1'b1;
    end
    // clear applied last so it wins
    if (clr_result) begin
      pending_d[result_rd_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  ////////////////////
  // dependency check
  ////////////////////

  always_comb begin
    rs_dep_o = 1'b0;
    for (int i = 0; i < NUM_RS; i++) begin
      rs_pending_o[i] = pending_q[issue_if.rs_addr[i]];
      // a register written back this cycle is no longer a hazard
      rs_dep_o = rs_dep_o
               | (regs_used_i[i] & pending_q[issue_if.rs_addr[i]]
                  & ~(clr_result & (result_rd_i == issue_if.rs_addr[i])));
    end
  end

endmodule
